// ==== source/rv_pkg.sv ====
package rv_pkg;

	localparam logic [31:0] RESET_PC = 32'h8000_0000; // First fetch address after reset

	// Major opcodes, bits 6:0 of the instruction word
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [5:0] {
		I_LUI, I_AUIPC, I_JAL, I_JALR,
		I_BEQ, I_BNE, I_BLT, I_BGE, I_BLTU, I_BGEU,
		I_LB, I_LH, I_LW, I_LBU, I_LHU,
		I_SB, I_SH, I_SW,
		I_ADDI, I_SLTI, I_SLTIU, I_XORI, I_ORI, I_ANDI,
		I_SLLI, I_SRLI, I_SRAI,
		I_ADD, I_SUB, I_SLL, I_SLT, I_SLTU, I_XOR, I_SRL, I_SRA, I_OR, I_AND,
		I_FENCE, I_ECALL, I_EBREAK,
		I_ILLEGAL
	} instr_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASSB
	} alu_op_e;

	typedef enum logic [1:0] {
		S_EXEC, // Executes one instruction per cycle
		S_MEM,  // Waits for the AXI transfer of a load or store
		S_HALT
	} state_e;

endpackage

// ==== source/rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder (
	input  logic [31:0]    i_instr,
	output rv_pkg::instr_e o_instr,
	output logic [4:0]     o_rs1,
	output logic [4:0]     o_rs2,
	output logic [4:0]     o_rd,
	output logic [31:0]    o_imm
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        f7_zero;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign f7_zero = (i_instr[31] == 1'b0) && (i_instr[29:25] == 5'd0); // Bit 30 decoded apart

	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];
	assign o_rd  = i_instr[11:7];

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'h000};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

	always_comb begin
		o_instr = rv_pkg::I_ILLEGAL;
		o_imm = imm_i; // I format unless the opcode says otherwise
		case (opcode)
			rv_pkg::OP_LUI: begin
				o_instr = rv_pkg::I_LUI;
				o_imm = imm_u;
			end
			rv_pkg::OP_AUIPC: begin
				o_instr = rv_pkg::I_AUIPC;
				o_imm = imm_u;
			end
			rv_pkg::OP_JAL: begin
				o_instr = rv_pkg::I_JAL;
				o_imm = imm_j;
			end
			rv_pkg::OP_JALR: begin
				if (funct3 == 3'b000)
					o_instr = rv_pkg::I_JALR;
			end
			rv_pkg::OP_BRANCH: begin
				o_imm = imm_b;
				case (funct3)
					3'b000: o_instr = rv_pkg::I_BEQ;
					3'b001: o_instr = rv_pkg::I_BNE;
					3'b100: o_instr = rv_pkg::I_BLT;
					3'b101: o_instr = rv_pkg::I_BGE;
					3'b110: o_instr = rv_pkg::I_BLTU;
					3'b111: o_instr = rv_pkg::I_BGEU;
					default: o_instr = rv_pkg::I_ILLEGAL;
				endcase
			end
			rv_pkg::OP_LOAD: begin
				case (funct3)
					3'b000: o_instr = rv_pkg::I_LB;
					3'b001: o_instr = rv_pkg::I_LH;
					3'b010: o_instr = rv_pkg::I_LW;
					3'b100: o_instr = rv_pkg::I_LBU;
					3'b101: o_instr = rv_pkg::I_LHU;
					default: o_instr = rv_pkg::I_ILLEGAL;
				endcase
			end
			rv_pkg::OP_STORE: begin
				o_imm = imm_s;
				case (funct3)
					3'b000: o_instr = rv_pkg::I_SB;
					3'b001: o_instr = rv_pkg::I_SH;
					3'b010: o_instr = rv_pkg::I_SW;
					default: o_instr = rv_pkg::I_ILLEGAL;
				endcase
			end
			rv_pkg::OP_IMM: begin
				case (funct3)
					3'b000: o_instr = rv_pkg::I_ADDI;
					3'b010: o_instr = rv_pkg::I_SLTI;
					3'b011: o_instr = rv_pkg::I_SLTIU;
					3'b100: o_instr = rv_pkg::I_XORI;
					3'b110: o_instr = rv_pkg::I_ORI;
					3'b111: o_instr = rv_pkg::I_ANDI;
					3'b001: begin
						if (f7_zero && !i_instr[30])
							o_instr = rv_pkg::I_SLLI;
					end
					default: begin
						if (f7_zero)
							o_instr = i_instr[30] ? rv_pkg::I_SRAI : rv_pkg::I_SRLI;
					end
				endcase
			end
			rv_pkg::OP_REG: begin
				if (f7_zero) begin
					case ({i_instr[30], funct3})
						4'b0000: o_instr = rv_pkg::I_ADD;
						4'b1000: o_instr = rv_pkg::I_SUB;
						4'b0001: o_instr = rv_pkg::I_SLL;
						4'b0010: o_instr = rv_pkg::I_SLT;
						4'b0011: o_instr = rv_pkg::I_SLTU;
						4'b0100: o_instr = rv_pkg::I_XOR;
						4'b0101: o_instr = rv_pkg::I_SRL;
						4'b1101: o_instr = rv_pkg::I_SRA;
						4'b0110: o_instr = rv_pkg::I_OR;
						4'b0111: o_instr = rv_pkg::I_AND;
						default: o_instr = rv_pkg::I_ILLEGAL;
					endcase
				end
			end
			rv_pkg::OP_FENCE: o_instr = rv_pkg::I_FENCE; // Ordering is trivial with one bus
			rv_pkg::OP_SYSTEM: begin
				if (funct3 == 3'b000)
					o_instr = i_instr[20] ? rv_pkg::I_EBREAK : rv_pkg::I_ECALL;
			end
			default: o_instr = rv_pkg::I_ILLEGAL;
		endcase
	end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
	input  logic        clk,
	input  logic        mif,
	input  logic [4:0]  i_rs1,
	input  logic [4:0]  i_rs2,
	output logic [31:0] o_rs1_data,
	output logic [31:0] o_rs2_data,
	input  logic        i_we,
	input  logic [4:0]  i_rd,
	input  logic [31:0] i_rd_data
);

	logic [31:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (i_we && (i_rd != 5'd0)) begin
			regs[i_rd] <= i_rd_data;
		end
	end

	assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!mif)
		((i_rs1 == 5'd0) |-> (o_rs1_data == 32'd0)) and ((i_rs2 == 5'd0) |-> (o_rs2_data == 32'd0)));

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu (
	input  rv_pkg::instr_e i_instr,
	input  logic [31:0]    i_a,
	input  logic [31:0]    i_b,
	input  logic [31:0]    i_imm,
	input  logic [31:0]    i_pc,
	output logic [31:0]    o_result,
	output logic           o_taken
);

	rv_pkg::alu_op_e op;
	logic [31:0]     opa;
	logic [31:0]     opb;

	always_comb begin
		op = rv_pkg::ALU_ADD; // ADD, ADDI and load/store addresses
		opa = i_a;
		opb = i_imm;
		case (i_instr)
			rv_pkg::I_SUB: op = rv_pkg::ALU_SUB;
			rv_pkg::I_SLL, rv_pkg::I_SLLI: op = rv_pkg::ALU_SLL;
			rv_pkg::I_SLT, rv_pkg::I_SLTI: op = rv_pkg::ALU_SLT;
			rv_pkg::I_SLTU, rv_pkg::I_SLTIU: op = rv_pkg::ALU_SLTU;
			rv_pkg::I_XOR, rv_pkg::I_XORI: op = rv_pkg::ALU_XOR;
			rv_pkg::I_SRL, rv_pkg::I_SRLI: op = rv_pkg::ALU_SRL;
			rv_pkg::I_SRA, rv_pkg::I_SRAI: op = rv_pkg::ALU_SRA;
			rv_pkg::I_OR, rv_pkg::I_ORI: op = rv_pkg::ALU_OR;
			rv_pkg::I_AND, rv_pkg::I_ANDI: op = rv_pkg::ALU_AND;
			rv_pkg::I_LUI: op = rv_pkg::ALU_PASSB;
			rv_pkg::I_AUIPC: opa = i_pc;
			rv_pkg::I_JAL, rv_pkg::I_JALR: begin
				opa = i_pc; // Link value is the return address
				opb = 32'd4;
			end
			default: op = rv_pkg::ALU_ADD;
		endcase
		if (i_instr inside {rv_pkg::I_ADD, rv_pkg::I_SUB, rv_pkg::I_SLL, rv_pkg::I_SLT,
				rv_pkg::I_SLTU, rv_pkg::I_XOR, rv_pkg::I_SRL, rv_pkg::I_SRA,
				rv_pkg::I_OR, rv_pkg::I_AND})
			opb = i_b;
	end

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD: o_result = opa + opb;
			rv_pkg::ALU_SUB: o_result = opa - opb; // rs1 minus rs2
			rv_pkg::ALU_SLL: o_result = opa << opb[4:0];
			rv_pkg::ALU_SLT: o_result = {31'd0, $signed(opa) < $signed(opb)};
			rv_pkg::ALU_SLTU: o_result = {31'd0, opa < opb};
			rv_pkg::ALU_XOR: o_result = opa ^ opb;
			rv_pkg::ALU_SRL: o_result = opa >> opb[4:0];
			rv_pkg::ALU_SRA: o_result = $signed(opa) >>> opb[4:0];
			rv_pkg::ALU_OR: o_result = opa | opb;
			rv_pkg::ALU_AND: o_result = opa & opb;
			rv_pkg::ALU_PASSB: o_result = opb; // LUI immediate is already shifted
			default: o_result = 32'd0;
		endcase
	end

	always_comb begin
		case (i_instr)
			rv_pkg::I_BEQ: o_taken = (i_a == i_b);
			rv_pkg::I_BNE: o_taken = (i_a != i_b);
			rv_pkg::I_BLT: o_taken = ($signed(i_a) < $signed(i_b));
			rv_pkg::I_BGE: o_taken = ($signed(i_a) >= $signed(i_b));
			rv_pkg::I_BLTU: o_taken = (i_a < i_b);
			rv_pkg::I_BGEU: o_taken = (i_a >= i_b);
			rv_pkg::I_JAL, rv_pkg::I_JALR: o_taken = 1'b1;
			default: o_taken = 1'b0;
		endcase
	end

endmodule

// ==== source/rv_lsu.sv ====
`timescale 1ns/10ps

module rv_lsu (
	input  logic           clk,
	input  logic           mif,
	input  logic           i_start,
	input  rv_pkg::instr_e i_instr,
	input  logic [31:0]    i_addr,
	input  logic [31:0]    i_wdata,
	output logic           o_done,
	output logic [31:0]    o_rdata,
	output logic           o_awvalid,
	input  logic           i_awready,
	output logic [31:0]    o_awaddr,
	output logic           o_wvalid,
	input  logic           i_wready,
	output logic [31:0]    o_wdata,
	output logic [3:0]     o_wstrb,
	input  logic           i_bvalid,
	output logic           o_bready,
	input  logic [1:0]     i_bresp,
	output logic           o_arvalid,
	input  logic           i_arready,
	output logic [31:0]    o_araddr,
	input  logic           i_rvalid,
	output logic           o_rready,
	input  logic [31:0]    i_rdata,
	input  logic [1:0]     i_rresp
);

	rv_pkg::instr_e ld_instr; // Load kind held for the R channel
	logic [1:0]     ld_off;
	logic           is_store;
	logic           b_done;
	logic           r_done;
	logic           busy;
	logic [31:0]    lane_data;
	logic [3:0]     lane_strb;
	logic [31:0]    rshift;
	logic [31:0]    ld_ext;

	assign is_store = i_instr inside {rv_pkg::I_SB, rv_pkg::I_SH, rv_pkg::I_SW};
	assign b_done = i_bvalid && o_bready;
	assign r_done = i_rvalid && o_rready;
	assign busy = o_awvalid || o_wvalid || o_bready || o_arvalid || o_rready;

	always_comb begin
		case (i_instr)
			rv_pkg::I_SB: begin
				lane_data = i_wdata << {i_addr[1:0], 3'b000};
				lane_strb = 4'b0001 << i_addr[1:0];
			end
			rv_pkg::I_SH: begin
				lane_data = i_wdata << {i_addr[1], 4'b0000}; // Bit 0 is ignored
				lane_strb = 4'b0011 << {i_addr[1], 1'b0};
			end
			default: begin
				lane_data = i_wdata;
				lane_strb = 4'b1111;
			end
		endcase
	end

	assign rshift = i_rdata >> {ld_off, 3'b000};

	always_comb begin
		case (ld_instr)
			rv_pkg::I_LB: ld_ext = {{24{rshift[7]}}, rshift[7:0]};
			rv_pkg::I_LBU: ld_ext = {24'd0, rshift[7:0]};
			rv_pkg::I_LH: ld_ext = {{16{rshift[15]}}, rshift[15:0]};
			rv_pkg::I_LHU: ld_ext = {16'd0, rshift[15:0]};
			default: ld_ext = i_rdata;
		endcase
	end

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			o_awvalid <= 1'b0;
			o_wvalid <= 1'b0;
			o_bready <= 1'b0;
			o_arvalid <= 1'b0;
			o_rready <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= b_done || r_done;
			if (o_awvalid && i_awready)
				o_awvalid <= 1'b0;
			if (o_wvalid && i_wready)
				o_wvalid <= 1'b0;
			if (b_done)
				o_bready <= 1'b0;
			if (o_arvalid && i_arready)
				o_arvalid <= 1'b0;
			if (r_done)
				o_rready <= 1'b0;
			if (i_start && is_store) begin
				o_awvalid <= 1'b1; // AW and W rise together
				o_wvalid <= 1'b1;
				o_bready <= 1'b1;
			end
			if (i_start && !is_store) begin
				o_arvalid <= 1'b1;
				o_rready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_start) begin
			o_awaddr <= {i_addr[31:2], 2'b00};
			o_araddr <= {i_addr[31:2], 2'b00};
			o_wdata <= lane_data;
			o_wstrb <= lane_strb;
			ld_instr <= i_instr;
			if (i_instr inside {rv_pkg::I_LH, rv_pkg::I_LHU})
				ld_off <= {i_addr[1], 1'b0};
			else
				ld_off <= i_addr[1:0];
		end
		if (r_done)
			o_rdata <= ld_ext; // Valid together with o_done
	end

	a_aw_stable: assert property (@(posedge clk) disable iff (!mif)
		(o_awvalid && !i_awready) |=> (o_awvalid && $stable(o_awaddr)));

	a_ar_stable: assert property (@(posedge clk) disable iff (!mif)
		(o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)));

	a_start_idle: assert property (@(posedge clk) disable iff (!mif)
		i_start |-> !busy);

	// The memory is expected to answer OKAY on both response channels
	a_resp_okay: assert property (@(posedge clk) disable iff (!mif)
		(b_done || r_done) |-> ((b_done ? i_bresp : i_rresp) == 2'b00));

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
	input  logic        clk,
	input  logic        mif,
	output logic [31:0] o_pc,
	input  logic [31:0] i_instr,
	output logic        o_halt,
	output logic        o_awvalid,
	input  logic        i_awready,
	output logic [31:0] o_awaddr,
	output logic        o_wvalid,
	input  logic        i_wready,
	output logic [31:0] o_wdata,
	output logic [3:0]  o_wstrb,
	input  logic        i_bvalid,
	output logic        o_bready,
	input  logic [1:0]  i_bresp,
	output logic        o_arvalid,
	input  logic        i_arready,
	output logic [31:0] o_araddr,
	input  logic        i_rvalid,
	output logic        o_rready,
	input  logic [31:0] i_rdata,
	input  logic [1:0]  i_rresp
);

	rv_pkg::state_e state;
	rv_pkg::instr_e instr;
	logic [31:0]    pc;
	logic [31:0]    pc_plus4;
	logic [31:0]    next_pc;
	logic [31:0]    jalr_target;
	logic [4:0]     rs1;
	logic [4:0]     rs2;
	logic [4:0]     rd;
	logic [31:0]    imm;
	logic [31:0]    rs1_data;
	logic [31:0]    rs2_data;
	logic [31:0]    alu_result;
	logic           alu_taken;
	logic           is_load;
	logic           is_mem;
	logic           is_halt;
	logic           writes_rd;
	logic           lsu_start;
	logic           lsu_done;
	logic [31:0]    lsu_rdata;
	logic           rd_we;
	logic [31:0]    rd_data;

	rv_decoder u_decoder (
		.i_instr(i_instr),
		.o_instr(instr),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rd(rd),
		.o_imm(imm)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.mif(mif),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_we(rd_we),
		.i_rd(rd),
		.i_rd_data(rd_data)
	);

	rv_alu u_alu (
		.i_instr(instr),
		.i_a(rs1_data),
		.i_b(rs2_data),
		.i_imm(imm),
		.i_pc(pc),
		.o_result(alu_result),
		.o_taken(alu_taken)
	);

	rv_lsu u_lsu (
		.clk(clk),
		.mif(mif),
		.i_start(lsu_start),
		.i_instr(instr),
		.i_addr(alu_result), // rs1 plus offset
		.i_wdata(rs2_data),
		.o_done(lsu_done),
		.o_rdata(lsu_rdata),
		.o_awvalid(o_awvalid),
		.i_awready(i_awready),
		.o_awaddr(o_awaddr),
		.o_wvalid(o_wvalid),
		.i_wready(i_wready),
		.o_wdata(o_wdata),
		.o_wstrb(o_wstrb),
		.i_bvalid(i_bvalid),
		.o_bready(o_bready),
		.i_bresp(i_bresp),
		.o_arvalid(o_arvalid),
		.i_arready(i_arready),
		.o_araddr(o_araddr),
		.i_rvalid(i_rvalid),
		.o_rready(o_rready),
		.i_rdata(i_rdata),
		.i_rresp(i_rresp)
	);

	assign is_load = instr inside {rv_pkg::I_LB, rv_pkg::I_LH, rv_pkg::I_LW,
		rv_pkg::I_LBU, rv_pkg::I_LHU};
	assign is_mem = is_load || (instr inside {rv_pkg::I_SB, rv_pkg::I_SH, rv_pkg::I_SW});
	assign is_halt = instr inside {rv_pkg::I_ECALL, rv_pkg::I_EBREAK, rv_pkg::I_ILLEGAL};
	assign writes_rd = !(instr inside {rv_pkg::I_BEQ, rv_pkg::I_BNE, rv_pkg::I_BLT,
		rv_pkg::I_BGE, rv_pkg::I_BLTU, rv_pkg::I_BGEU, rv_pkg::I_FENCE}) && !is_halt;

	assign lsu_start = (state == rv_pkg::S_EXEC) && is_mem;

	// Instruction word stays valid in S_MEM because the PC is held
	assign rd_we = ((state == rv_pkg::S_EXEC) && writes_rd && !is_mem) || (lsu_done && is_load);
	assign rd_data = lsu_done ? lsu_rdata : alu_result;

	assign pc_plus4 = pc + 32'd4;
	assign jalr_target = (rs1_data + imm) & ~32'd1;

	always_comb begin
		if (instr == rv_pkg::I_JALR)
			next_pc = jalr_target;
		else if (alu_taken)
			next_pc = pc + imm; // JAL and taken branches
		else
			next_pc = pc_plus4;
	end

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			pc <= rv_pkg::RESET_PC;
			state <= rv_pkg::S_EXEC;
		end else begin
			case (state)
				rv_pkg::S_EXEC: begin
					if (is_halt)
						state <= rv_pkg::S_HALT;
					else if (is_mem)
						state <= rv_pkg::S_MEM;
					else
						pc <= next_pc;
				end
				rv_pkg::S_MEM: begin
					if (lsu_done) begin
						pc <= pc_plus4;
						state <= rv_pkg::S_EXEC;
					end
				end
				default: state <= rv_pkg::S_HALT; // Left only through reset
			endcase
		end
	end

	assign o_pc = pc;
	assign o_halt = (state == rv_pkg::S_HALT);

	a_pc_aligned: assert property (@(posedge clk) disable iff (!mif) o_pc[1:0] == 2'b00);

endmodule

// ==== test/tb_axil_mem.sv ====
`timescale 1ns/10ps

module tb_axil_mem (
	input  logic        clk,
	input  logic        mif,
	input  logic [3:0]  i_rnd,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  logic [31:0] i_awaddr,
	input  logic        i_wvalid,
	output logic        o_wready,
	input  logic [31:0] i_wdata,
	input  logic [3:0]  i_wstrb,
	output logic        o_bvalid,
	input  logic        i_bready,
	output logic [1:0]  o_bresp,
	input  logic        i_arvalid,
	output logic        o_arready,
	input  logic [31:0] i_araddr,
	output logic        o_rvalid,
	input  logic        i_rready,
	output logic [31:0] o_rdata,
	output logic [1:0]  o_rresp
);

	logic [31:0] mem [0:255]; // 1 KB, word index from address bits 9:2
	logic        aw_have;
	logic        w_have;
	logic        ar_have;
	logic [31:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0]  w_strb;
	logic [31:0] ar_addr;
	logic        do_write;
	logic        do_read;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3}; // Each word differs
	end

	assign o_awready = !aw_have && i_rnd[0]; // Random back-pressure
	assign o_wready = !w_have && i_rnd[1];
	assign o_arready = !ar_have && !o_rvalid && i_rnd[2];
	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;
	assign do_write = aw_have && w_have && !o_bvalid && i_rnd[3];
	assign do_read = ar_have && !o_rvalid && i_rnd[3];

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			aw_have <= 1'b0;
			w_have <= 1'b0;
			ar_have <= 1'b0;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			if (i_awvalid && o_awready)
				aw_have <= 1'b1;
			if (i_wvalid && o_wready)
				w_have <= 1'b1;
			if (i_arvalid && o_arready)
				ar_have <= 1'b1;
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
			if (do_write) begin
				aw_have <= 1'b0;
				w_have <= 1'b0;
				o_bvalid <= 1'b1;
			end
			if (do_read) begin
				ar_have <= 1'b0;
				o_rvalid <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (i_awvalid && o_awready)
			aw_addr <= i_awaddr;
		if (i_wvalid && o_wready) begin
			w_data <= i_wdata;
			w_strb <= i_wstrb;
		end
		if (i_arvalid && o_arready)
			ar_addr <= i_araddr;
		if (do_write) begin
			for (int k = 0; k < 4; k++)
				if (w_strb[k])
					mem[aw_addr[9:2]][8*k +: 8] <= w_data[8*k +: 8];
		end
		if (do_read)
			o_rdata <= mem[ar_addr[9:2]];
	end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;

	logic        clk;
	logic        mif;
	logic [3:0]  rnd;
	logic [31:0] o_pc;
	logic [31:0] instr;
	logic        o_halt;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;

	logic [31:0] prog [0:255];
	logic        skip [0:255]; // Addresses that the predicted path jumps over
	int          n_instr;
	int          next_slot;
	logic [15:0] lfsr;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0]  exp_strb [$];
	int          aw_idx;
	int          w_idx;
	logic [31:0] pc_idx;

	rv_core UUT (
		.clk(clk), .mif(mif), .o_pc(o_pc), .i_instr(instr), .o_halt(o_halt),
		.o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
		.o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
		.i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
		.o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
		.i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp)
	);

	tb_axil_mem u_mem (
		.clk(clk), .mif(mif), .i_rnd(rnd),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
	);

	always #50 clk = ~clk;

	assign pc_idx = (o_pc - rv_pkg::RESET_PC) >> 2;
	assign instr = (pc_idx < 256) ? prog[pc_idx[7:0]] : 32'd0;

	task automatic report_error(input string what);
		$display("Some tests failed");
		$display("ERROR at %0t: %s", $time, what);
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("Some tests failed");
		$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
		$fatal(1);
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_pkg::OP_STORE}; // Base is always x0
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
	endfunction

	// Reference results straight from the RV32I rules
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] byte_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	task automatic put_word(input logic [31:0 ] w);
		prog[n_instr] = w;
		n_instr++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
		put_word(s_type(next_slot[11:0], rs, 3'b010));
		expect_store(next_slot, value, 4'hf);
		next_slot += 4;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12; // ADDI sign-extends the low part
		put_word({hi[19:0], rd, rv_pkg::OP_LUI});
		put_word(i_type(v[11:0], rd, 3'd0, rd, rv_pkg::OP_IMM));
	endtask

	task automatic build_program();
		logic [31:0] a, b, r, pc;
		logic [2:0]  f3;
		logic [2:0]  imm_f3 [6];
		logic [2:0]  br_f3 [6];
		logic [4:0]  p1 [3];
		logic [4:0]  p2 [3];
		logic [31:0] ops [3];
		int          idx, marker;
		imm_f3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		take_bits(32, a);
		take_bits(32, b);
		if (a == b)
			b = ~a;
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int i = 0; i < 10; i++) begin
			f3 = (i < 8) ? i[2:0] : ((i == 8) ? 3'd0 : 3'd5); // Two alternate forms last
			put_word(r_type({1'b0, i >= 8, 5'd0}, 5'd2, 5'd1, f3, 5'd5));
			store_result(5'd5, alu_model(f3, i >= 8, a, b));
		end
		for (int i = 0; i < 6; i++) begin
			take_bits(12, r);
			put_word(i_type(r[11:0], 5'd1, imm_f3[i], 5'd5, rv_pkg::OP_IMM));
			store_result(5'd5, alu_model(imm_f3[i], 1'b0, a, {{20{r[11]}}, r[11:0]}));
		end
		for (int i = 0; i < 3; i++) begin
			take_bits(5, r);
			f3 = (i == 0) ? 3'd1 : 3'd5;
			put_word(i_type({1'b0, i == 2, 5'd0, r[4:0]}, 5'd1, f3, 5'd5, rv_pkg::OP_IMM));
			store_result(5'd5, alu_model(f3, i == 2, a, r));
		end
		take_bits(20, r);
		put_word({r[19:0], 5'd5, rv_pkg::OP_LUI});
		store_result(5'd5, {r[19:0], 12'd0});
		pc = rv_pkg::RESET_PC + 4 * n_instr;
		put_word({r[19:0], 5'd5, rv_pkg::OP_AUIPC});
		store_result(5'd5, pc + {r[19:0], 12'd0});
		for (int k = 0; k < 4; k++) begin
			put_word(s_type(12'h080 + k[11:0], 5'd2, 3'b000));
			expect_store(32'h80, {24'd0, b[7:0]} << (8 * k), 4'b0001 << k);
		end
		for (int k = 0; k < 4; k += 2) begin
			put_word(s_type(12'h084 + k[11:0], 5'd2, 3'b001));
			expect_store(32'h84, {16'd0, b[15:0]} << (8 * k), 4'b0011 << k);
		end
		put_word(s_type(12'h090, 5'd1, 3'b010));
		expect_store(32'h90, a, 4'hf);
		for (int k = 0; k < 4; k++) begin
			put_word(i_type(12'h090 + k[11:0], 5'd0, 3'b000, 5'd5, rv_pkg::OP_LOAD));
			store_result(5'd5, {{24{a[8*k+7]}}, a[8*k +: 8]});
			put_word(i_type(12'h090 + k[11:0], 5'd0, 3'b100, 5'd5, rv_pkg::OP_LOAD));
			store_result(5'd5, {24'd0, a[8*k +: 8]});
		end
		for (int k = 0; k < 4; k += 2) begin
			put_word(i_type(12'h090 + k[11:0], 5'd0, 3'b001, 5'd5, rv_pkg::OP_LOAD));
			store_result(5'd5, {{16{a[8*k+15]}}, a[8*k +: 16]});
			put_word(i_type(12'h090 + k[11:0], 5'd0, 3'b101, 5'd5, rv_pkg::OP_LOAD));
			store_result(5'd5, {16'd0, a[8*k +: 16]});
		end
		put_word(i_type(12'h080, 5'd0, 3'b010, 5'd5, rv_pkg::OP_LOAD));
		store_result(5'd5, {4{b[7:0]}}); // Four byte stores filled the word
		put_word(i_type(12'h084, 5'd0, 3'b010, 5'd5, rv_pkg::OP_LOAD));
		store_result(5'd5, {2{b[15:0]}});
		put_word(i_type(12'd0, 5'd0, 3'd0, 5'd0, rv_pkg::OP_FENCE));
		p1 = '{5'd1, 5'd2, 5'd1};
		p2 = '{5'd2, 5'd1, 5'd1};
		ops = '{a, b, a};
		marker = 32'h100;
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 3; j++) begin
				idx = n_instr;
				put_word(b_type(13'd12, p2[j], p1[j], br_f3[i]));
				put_word(i_type(marker[11:0], 5'd0, 3'd0, 5'd6, rv_pkg::OP_IMM));
				put_word(j_type(21'd8, 5'd0));
				put_word(i_type(marker[11:0] + 12'd1, 5'd0, 3'd0, 5'd6, rv_pkg::OP_IMM));
				if (branch_model(br_f3[i], ops[j], (j == 1) ? a : ((j == 2) ? a : b))) begin
					skip[idx + 1] = 1'b1;
					skip[idx + 2] = 1'b1;
					store_result(5'd6, marker + 1);
				end else begin
					skip[idx + 3] = 1'b1;
					store_result(5'd6, marker);
				end
				marker += 2;
			end
		end
		pc = rv_pkg::RESET_PC + 4 * n_instr;
		put_word(j_type(21'd8, 5'd7));
		skip[n_instr] = 1'b1;
		put_word(i_type(12'd1, 5'd0, 3'd0, 5'd5, rv_pkg::OP_IMM));
		store_result(5'd7, pc + 4);
		put_word({20'h80000, 5'd8, rv_pkg::OP_LUI});
		pc = rv_pkg::RESET_PC + 4 * n_instr;
		idx = 4 * (n_instr + 2) + 1; // Odd target tests the cleared bit 0
		put_word(i_type(idx[11:0], 5'd8, 3'd0, 5'd9, rv_pkg::OP_JALR));
		skip[n_instr] = 1'b1;
		put_word(i_type(12'd1, 5'd0, 3'd0, 5'd5, rv_pkg::OP_IMM));
		store_result(5'd9, pc + 4);
		put_word(i_type(12'd1, 5'd0, 3'd0, 5'd0, rv_pkg::OP_SYSTEM)); // EBREAK
	endtask

	always @(posedge clk) begin
		logic [31:0] bits;
		#5;
		take_bits(4, bits);
		rnd = bits[3:0];
	end

	// Write handshakes against the expected store stream
	always @(posedge clk) begin
		if (mif && awvalid && awready) begin
			assert (aw_idx < exp_addr.size()) else report_error("unexpected extra store address");
			assert (awaddr == exp_addr[aw_idx]) else
				report_mismatch("o_awaddr", exp_addr[aw_idx], awaddr);
			aw_idx++;
		end
		if (mif && wvalid && wready) begin
			assert (w_idx < exp_data.size()) else report_error("unexpected extra store data");
			assert (wstrb == exp_strb[w_idx]) else
				report_mismatch("o_wstrb", {28'd0, exp_strb[w_idx]}, {28'd0, wstrb});
			assert ((wdata & byte_mask(wstrb)) == (exp_data[w_idx] & byte_mask(wstrb))) else
				report_mismatch("o_wdata", exp_data[w_idx], wdata);
			w_idx++;
		end
		if (mif && !o_halt) begin
			assert (pc_idx < n_instr && !skip[pc_idx[7:0]]) else
				report_error("o_pc reached an address off the predicted path");
		end
	end

	a_reset_state: assert property (@(posedge clk) !mif |->
		(o_pc == rv_pkg::RESET_PC && !awvalid && !wvalid && !arvalid && !bready && !rready &&
		!o_halt))
		else report_error("core outputs are wrong during reset");

	a_halt_frozen: assert property (@(posedge clk) disable iff (!mif) o_halt |=>
		(o_halt && $stable(o_pc) && !awvalid && !wvalid && !arvalid))
		else report_error("core left the halted state or started a transfer");

	initial begin
		int cycles;
		clk = 1'b0;
		mif = 1'b1;
		rnd = 4'd0;
		lfsr = 16'd18828;
		n_instr = 0;
		next_slot = 32'h100;
		aw_idx = 0;
		w_idx = 0;
		for (int i = 0; i < 256; i++) begin
			prog[i] = 32'd0;
			skip[i] = 1'b0;
		end
		build_program();
		#10 mif = 1'b0;
		repeat (4) @(posedge clk);
		#5 mif = 1'b1;
		cycles = 0;
		while (!o_halt && cycles < 5000) begin
			@(posedge clk);
			cycles++;
		end
		if (!o_halt) begin
			$display("Some tests failed");
			$display("ERROR at %0t: core did not halt within %0d cycles", $time, cycles);
			$fatal(1);
		end
		cycles = 0;
		while (cycles < 20) begin // Halted core must stay quiet
			@(posedge clk);
			cycles++;
		end
		if (aw_idx == exp_addr.size() && w_idx == exp_data.size()) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$display("ERROR: saw %0d of %0d expected stores", w_idx, exp_data.size());
			$fatal(1);
		end
	end

endmodule

// ==== filelist.f ====
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
test/tb_axil_mem.sv
test/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o vsim
	@out="$$(./obj_dir/vsim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
